/* dv/exe_stage_props.sv */
`timescale 1ns/1ns

module exe_stage_props (
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic start,
	input logic busy,
	input logic done
);
	import alu_op_pkg::*;

	// done is a single-cycle pulse
	done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("divider done held for more than one cycle");

	// synchronous reset leaves the divider idle
	reset_idle: assert property (@(posedge clk) !rst_n |=> (!busy && !done))
		else $error("divider not idle after reset");

	// a flush abandons the running divide
	flush_abort: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && flush) |=> (!busy && !done))
		else $error("flush did not return the divider to idle");

	// fixed latency from start to done when nothing interferes
	fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(start && !busy && !flush) ##1 (!flush)[*div_cycles] |=> done)
		else $error("divider done missing div_cycles + 1 cycles after start");

endmodule

bind div exe_stage_props u_props (
	.clk   (clk),
	.rst_n (rst_n),
	.flush (flush),
	.start (start),
	.busy  (busy),
	.done  (done)
);

/* dv/exe_stage_tb.sv */
`timescale 1ns/1ns

module exe_stage_tb;
	import alu_op_pkg::*;
	import exe_types_pkg::*;

	localparam logic [1:0] chk_none = 2'b00;
	localparam logic [1:0] chk_flag = 2'b01;
	localparam logic [1:0] chk_all = 2'b11;
	localparam int n_rand_div = 20;
	// random, four directed and one flushed
	localparam int n_divs = n_rand_div + 5;

	// result checked under chk[1], overflow and zero under chk[0]
	typedef struct packed {
		exe_req_t   req;
		logic [1:0] chk;
		exe_resp_t  exp;
	} vec_t;

	logic      clk;
	logic      rst_n;
	logic      flush;
	exe_req_t  req;
	exe_resp_t resp;
	logic      stall;

	vec_t   vecs[$];
	string  names[$];
	integer seed;
	int     n_checks;
	int     n_errors;

	exe_stage uut (
		.clk   (clk),
		.rst_n (rst_n),
		.flush (flush),
		.req   (req),
		.resp  (resp),
		.stall (stall)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic add_row(input string name, input alu_op_e op, input logic [31:0] a,
		input logic [31:0] b, input logic [4:0] sa, input logic [1:0] chk,
		input logic [31:0] res, input logic ovf, input logic zf);
		vec_t v;
		v.req.op = op;
		v.req.num1 = a;
		v.req.num2 = b;
		v.req.sa = sa;
		v.chk = chk;
		v.exp.result = res;
		v.exp.overflow = ovf;
		v.exp.zero = zf;
		vecs.push_back(v);
		names.push_back(name);
	endtask

	task automatic build_table();
		// hi/lo cleared by reset
		add_row("mfhi_reset", op_mfhi, 0, 0, 0, chk_all, 32'h00000000, 0, 1);
		add_row("mflo_reset", op_mflo, 0, 0, 0, chk_all, 32'h00000000, 0, 1);
		add_row("and", op_and, 32'hf0f01234, 32'h0ff05678, 0, chk_all, 32'h00f01230, 0, 0);
		add_row("or", op_or, 32'hf0f01234, 32'h0ff05678, 0, chk_all, 32'hfff0567c, 0, 0);
		add_row("xor", op_xor, 32'hf0f01234, 32'h0ff05678, 0, chk_all, 32'hff00444c, 0, 0);
		add_row("nor", op_nor, 32'hf0f01234, 32'h0ff05678, 0, chk_all, 32'h000fa983, 0, 0);
		// immediate logic sees only the low half of num2
		add_row("andi", op_andi, 32'hf0f01234, 32'hffff8001, 0, chk_all, 32'h00000000, 0, 1);
		add_row("ori", op_ori, 32'h12340000, 32'hffffabcd, 0, chk_all, 32'h1234abcd, 0, 0);
		add_row("xori", op_xori, 32'h0000ffff, 32'hffff0f0f, 0, chk_all, 32'h0000f0f0, 0, 0);
		add_row("lui", op_lui, 32'h0, 32'h0000beef, 0, chk_all, 32'hbeef0000, 0, 0);
		add_row("sll", op_sll, 32'h0, 32'h00000001, 31, chk_all, 32'h80000000, 0, 0);
		add_row("srl", op_srl, 32'h0, 32'h80000000, 4, chk_all, 32'h08000000, 0, 0);
		add_row("sra", op_sra, 32'h0, 32'h80000000, 4, chk_all, 32'hf8000000, 0, 0);
		add_row("sllv", op_sllv, 32'h24, 32'h000000f0, 0, chk_all, 32'h00000f00, 0, 0);
		add_row("srlv", op_srlv, 32'h8, 32'hf0000000, 0, chk_all, 32'h00f00000, 0, 0);
		add_row("srav", op_srav, 32'h8, 32'hf0000000, 0, chk_all, 32'hfff00000, 0, 0);
		add_row("slt", op_slt, 32'hffffffff, 32'h1, 0, chk_all, 32'h1, 0, 0);
		add_row("sltu", op_sltu, 32'hffffffff, 32'h1, 0, chk_all, 32'h0, 0, 1);
		add_row("slti", op_slti, 32'h5, 32'hfffffffb, 0, chk_all, 32'h0, 0, 1);
		add_row("sltiu", op_sltiu, 32'h5, 32'hfffffffb, 0, chk_all, 32'h1, 0, 0);
		// overflow forces a zero result and so sets the zero flag
		add_row("add_ovf", op_add, 32'h7fffffff, 32'h1, 0, chk_all, 32'h0, 1, 1);
		add_row("addu_wrap", op_addu, 32'h7fffffff, 32'h1, 0, chk_all, 32'h80000000, 0, 0);
		add_row("addi_ovf", op_addi, 32'h80000000, 32'hffffffff, 0, chk_all, 32'h0, 1, 1);
		add_row("addiu_wrap", op_addiu, 32'h80000000, 32'hffffffff, 0, chk_all, 32'h7fffffff, 0, 0);
		add_row("sub_ovf", op_sub, 32'h80000000, 32'h1, 0, chk_all, 32'h0, 1, 1);
		add_row("subu_wrap", op_subu, 32'h80000000, 32'h1, 0, chk_all, 32'h7fffffff, 0, 0);
		add_row("sub", op_sub, 32'h3, 32'h5, 0, chk_all, 32'hfffffffe, 0, 0);
		add_row("j", op_j, 32'h00400000, 32'h100, 0, chk_all, 32'h00400100, 0, 0);
		add_row("lw", op_lw, 32'h10000000, 32'hfffffffc, 0, chk_all, 32'h0ffffffc, 0, 0);
		add_row("mtc0", op_mtc0, 32'h1, 32'hdeadbeef, 0, chk_all, 32'hdeadbeef, 0, 0);
		// branches, zero flag is the taken condition
		add_row("beq_t", op_beq, 32'h5, 32'h5, 0, chk_flag, 0, 0, 1);
		add_row("beq_n", op_beq, 32'h5, 32'h6, 0, chk_flag, 0, 0, 0);
		add_row("bne_t", op_bne, 32'h5, 32'h6, 0, chk_flag, 0, 0, 1);
		add_row("bne_n", op_bne, 32'h5, 32'h5, 0, chk_flag, 0, 0, 0);
		add_row("bgtz_t", op_bgtz, 32'h1, 0, 0, chk_flag, 0, 0, 1);
		add_row("bgtz_n", op_bgtz, 32'hffffffff, 0, 0, chk_flag, 0, 0, 0);
		add_row("blez_t", op_blez, 32'h0, 0, 0, chk_flag, 0, 0, 1);
		add_row("blez_n", op_blez, 32'h1, 0, 0, chk_flag, 0, 0, 0);
		add_row("bltz_t", op_bltz, 32'hffffffff, 0, 0, chk_flag, 0, 0, 1);
		add_row("bltz_n", op_bltz, 32'h0, 0, 0, chk_flag, 0, 0, 0);
		add_row("bgez_t", op_bgez, 32'h0, 0, 0, chk_flag, 0, 0, 1);
		add_row("bgez_n", op_bgez, 32'h80000000, 0, 0, chk_flag, 0, 0, 0);
		add_row("bltzal_t", op_bltzal, 32'h80000000, 0, 0, chk_flag, 0, 0, 1);
		add_row("bltzal_n", op_bltzal, 32'h7fffffff, 0, 0, chk_flag, 0, 0, 0);
		add_row("bgezal_t", op_bgezal, 32'h7fffffff, 0, 0, chk_flag, 0, 0, 1);
		add_row("bgezal_n", op_bgezal, 32'hffffffff, 0, 0, chk_flag, 0, 0, 0);
		// hi/lo writes land on the edge before the next row
		add_row("mthi", op_mthi, 32'h13579bdf, 0, 0, chk_none, 0, 0, 0);
		add_row("mtlo", op_mtlo, 32'h2468ace0, 0, 0, chk_none, 0, 0, 0);
		add_row("mfhi_mthi", op_mfhi, 0, 0, 0, chk_all, 32'h13579bdf, 0, 0);
		add_row("mflo_mtlo", op_mflo, 0, 0, 0, chk_all, 32'h2468ace0, 0, 0);
		add_row("mult", op_mult, 32'hfffffffe, 32'h3, 0, chk_none, 0, 0, 0);
		add_row("mfhi_mult", op_mfhi, 0, 0, 0, chk_all, 32'hffffffff, 0, 0);
		add_row("mflo_mult", op_mflo, 0, 0, 0, chk_all, 32'hfffffffa, 0, 0);
		add_row("multu", op_multu, 32'hfffffffe, 32'h3, 0, chk_none, 0, 0, 0);
		add_row("mfhi_multu", op_mfhi, 0, 0, 0, chk_all, 32'h00000002, 0, 0);
		add_row("mflo_multu", op_mflo, 0, 0, 0, chk_all, 32'hfffffffa, 0, 0);
		add_row("multu_max", op_multu, 32'hffffffff, 32'hffffffff, 0, chk_none, 0, 0, 0);
		add_row("mfhi_max", op_mfhi, 0, 0, 0, chk_all, 32'hfffffffe, 0, 0);
		add_row("mflo_max", op_mflo, 0, 0, 0, chk_all, 32'h00000001, 0, 0);
	endtask

	task automatic apply_table();
		vec_t v;
		for (int i = 0; i < vecs.size(); i++) begin
			v = vecs[i];
			@(negedge clk);
			req = v.req;
			#1;
			if (v.chk[1]) begin
				check_word(names[i], v.exp.result, resp.result);
			end
			if (v.chk[0]) begin
				check_word({names[i], " overflow"}, v.exp.overflow, resp.overflow);
				check_word({names[i], " zero"}, v.exp.zero, resp.zero);
			end
		end
	endtask

	// quotient and remainder, remainder signed like the dividend
	function automatic hilo_t div_model(input logic sgn, input logic [31:0] a,
		input logic [31:0] b);
		hilo_t r;
		if (b == 0) begin
			r.lo = '1;
			r.hi = a;
		end else if (sgn) begin
			r.lo = $signed(a) / $signed(b);
			r.hi = $signed(a) % $signed(b);
		end else begin
			r.lo = a / b;
			r.hi = a % b;
		end
		return r;
	endfunction

	task automatic read_hilo(input string name, input hilo_t exp);
		@(negedge clk);
		req = '0;
		req.op = op_mflo;
		#1;
		check_word({name, " lo"}, exp.lo, resp.result);
		@(negedge clk);
		req.op = op_mfhi;
		#1;
		check_word({name, " hi"}, exp.hi, resp.result);
	endtask

	task automatic run_div(input string name, input logic sgn, input logic [31:0] a,
		input logic [31:0] b);
		hilo_t exp;
		int    n;
		exp = div_model(sgn, a, b);
		n = 0;
		@(negedge clk);
		req = '0;
		if (sgn) begin
			req.op = op_div;
		end else begin
			req.op = op_divu;
		end
		req.num1 = a;
		req.num2 = b;
		#1;
		if (!stall) begin
			n_errors++;
			$display("stall did not rise when %s was issued", name);
		end
		// request held until the stall drops, hi/lo written on the next edge
		while (stall && n < 3 * div_cycles) begin
			@(negedge clk);
			n++;
		end
		check_word({name, " stall cycles"}, div_cycles + 1, n);
		read_hilo(name, exp);
	endtask

	task automatic flush_div();
		hilo_t keep;
		keep.hi = 32'h0badf00d;
		keep.lo = 32'h600dcafe;
		@(negedge clk);
		req = '0;
		req.op = op_mthi;
		req.num1 = keep.hi;
		@(negedge clk);
		req.op = op_mtlo;
		req.num1 = keep.lo;
		@(negedge clk);
		req.op = op_div;
		req.num1 = 32'h76543210;
		req.num2 = 32'h13;
		repeat (10) @(negedge clk);
		check_word("flush busy stall", 1, stall);
		flush = 1'b1;
		@(negedge clk);
		check_word("flush stall", 0, stall);
		flush = 1'b0;
		// bubble replaces the flushed divide
		req = '0;
		read_hilo("flush", keep);
	endtask

	initial begin
		int limit;
		#1;
		limit = vecs.size() + 40 * n_divs + 100;
		repeat (limit) @(posedge clk);
		$display("timeout: run still going after %0d cycles", limit);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sh;
		rst_n = 1'b0;
		flush = 1'b0;
		req = '0;
		seed = 32'h014c7215;
		n_checks = 0;
		n_errors = 0;
		build_table();
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		check_word("stall_reset", 0, stall);
		apply_table();
		run_div("div_by_zero_s", 1'b1, 32'hfffffff9, 32'h0);
		run_div("div_by_zero_u", 1'b0, 32'h12345678, 32'h0);
		run_div("div_neg_s", 1'b1, 32'hfffffff9, 32'h2);
		run_div("divu_big", 1'b0, 32'hfffffff0, 32'h7);
		for (int i = 0; i < n_rand_div; i++) begin
			a = $random(seed);
			b = $random(seed);
			sh = $random(seed);
			// spread the divisor over all magnitudes and both signs
			b = b >> sh[4:0];
			if (sh[6]) begin
				b = -b;
			end
			run_div($sformatf("div_rand_%0d", i), sh[5], a, b);
		end
		flush_div();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ns

module alu (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     flush,
	input  exe_types_pkg::exe_req_t  req,
	input  exe_types_pkg::hilo_t     hilo,
	output exe_types_pkg::exe_resp_t resp,
	output exe_types_pkg::hilo_t     wide,
	output logic                     wide_done,
	output logic                     stall
);
	import alu_op_pkg::*;
	import exe_types_pkg::*;

	logic [data_w-1:0]          a;
	logic [data_w-1:0]          b;
	logic [data_w-1:0]          sum;
	logic [data_w-1:0]          diff;
	logic [data_w-1:0]          ans;
	logic                       ovf_add;
	logic                       ovf_sub;
	logic                       ovf;
	logic                       is_branch;
	logic                       taken;
	logic signed [2*data_w-1:0] prod_s;
	logic [2*data_w-1:0]        prod_u;
	logic                       div_op;
	logic                       div_start;
	logic                       div_busy;
	logic                       div_done;
	hilo_t                      div_qr;

	assign a = req.num1;
	assign b = req.num2;
	assign sum = a + b;
	assign diff = a - b;

	// signed overflow, operands agree in sign but the result does not
	assign ovf_add = ((req.op == op_add) || (req.op == op_addi)) &&
		(a[data_w-1] == b[data_w-1]) && (sum[data_w-1] != a[data_w-1]);
	assign ovf_sub = (req.op == op_sub) &&
		(a[data_w-1] != b[data_w-1]) && (diff[data_w-1] != a[data_w-1]);
	assign ovf = ovf_add || ovf_sub;

	always_comb begin
		case (req.op)
			op_and:   ans = a & b;
			op_or:    ans = a | b;
			op_xor:   ans = a ^ b;
			op_nor:   ans = ~(a | b);
			// immediate logic uses the low half only
			op_andi:  ans = a & {16'b0, b[15:0]};
			op_ori:   ans = a | {16'b0, b[15:0]};
			op_xori:  ans = a ^ {16'b0, b[15:0]};
			op_lui:   ans = {b[15:0], 16'b0};
			op_sll:   ans = b << req.sa;
			op_srl:   ans = b >> req.sa;
			op_sra:   ans = $signed(b) >>> req.sa;
			op_sllv:  ans = b << a[4:0];
			op_srlv:  ans = b >> a[4:0];
			op_srav:  ans = $signed(b) >>> a[4:0];
			op_mfhi:  ans = hilo.hi;
			op_mflo:  ans = hilo.lo;
			op_mthi,
			op_mtlo:  ans = a;
			op_add,
			op_addu,
			op_addi,
			op_addiu: ans = sum;
			op_sub,
			op_subu:  ans = diff;
			op_slt,
			op_slti:  ans = {{(data_w-1){1'b0}}, $signed(a) < $signed(b)};
			op_sltu,
			op_sltiu: ans = {{(data_w-1){1'b0}}, a < b};
			op_j:     ans = sum;
			op_beq,
			op_bne:   ans = diff;
			// effective address
			op_lb, op_lbu, op_lh, op_lhu, op_lw,
			op_sb, op_sh, op_sw: ans = sum;
			op_mtc0:  ans = b;
			op_eret:  ans = '0;
			default:  ans = '0;
		endcase
	end

	// branch condition
	always_comb begin
		is_branch = 1'b1;
		case (req.op)
			op_beq:    taken = (a == b);
			op_bne:    taken = (a != b);
			op_bgtz:   taken = !a[data_w-1] && (a != '0);
			op_blez:   taken = a[data_w-1] || (a == '0);
			op_bltz,
			op_bltzal: taken = a[data_w-1];
			op_bgez,
			op_bgezal: taken = !a[data_w-1];
			default: begin
				is_branch = 1'b0;
				taken = 1'b0;
			end
		endcase
	end

	always_comb begin
		resp.result = ovf ? '0 : ans;
		resp.overflow = ovf;
		// the forced zero result on overflow counts as zero
		resp.zero = is_branch ? taken : (ovf || (ans == '0));
	end

	// full-width products
	assign prod_s = $signed(a) * $signed(b);
	assign prod_u = {{data_w{1'b0}}, a} * {{data_w{1'b0}}, b};

	// the divider starts once per held div op
	assign div_op = (req.op == op_div) || (req.op == op_divu);
	assign div_start = div_op && !div_busy && !div_done && !flush;
	assign stall = div_start || div_busy;
	assign wide_done = div_done;

	div u_div (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.start     (div_start),
		.is_signed (req.op == op_div),
		.dividend  (a),
		.divisor   (b),
		.busy      (div_busy),
		.done      (div_done),
		.quot_rem  (div_qr)
	);

	always_comb begin
		case (req.op)
			op_mult:  wide = prod_s;
			op_multu: wide = prod_u;
			op_div,
			op_divu:  wide = div_qr;
			default:  wide = '0;
		endcase
	end

endmodule

/* logic/alu_op_pkg.sv */
package alu_op_pkg;

	// machine word width
	localparam int data_w = 32;

	// divider iterations, one quotient bit per cycle
	localparam int div_cycles = 32;
	localparam int div_cnt_w = $clog2(div_cycles);

	// execute-stage operation encoding, nop must stay zero
	typedef enum logic [7:0] {
		op_nop = 8'h00,
		// logic and immediate logic
		op_and,
		op_or,
		op_xor,
		op_nor,
		op_andi,
		op_ori,
		op_xori,
		op_lui,
		// shifts
		op_sll,
		op_srl,
		op_sra,
		op_sllv,
		op_srlv,
		op_srav,
		// hi/lo moves
		op_mfhi,
		op_mflo,
		op_mthi,
		op_mtlo,
		// arithmetic
		op_add, op_addu, op_sub, op_subu,
		op_addi, op_addiu,
		op_slt, op_sltu, op_slti, op_sltiu,
		// multiply and divide
		op_mult, op_multu, op_div, op_divu,
		// jump target sum
		op_j,
		// branches
		op_beq, op_bne, op_bgtz, op_blez,
		op_bltz, op_bgez, op_bltzal, op_bgezal,
		// loads and stores, address sum only
		op_lb, op_lbu, op_lh, op_lhu, op_lw,
		op_sb, op_sh, op_sw,
		// privileged
		op_mtc0,
		op_eret
	} alu_op_e;

endpackage

/* logic/div.sv */
`timescale 1ns/1ns

module div (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          flush,
	input  logic                          start,
	input  logic                          is_signed,
	input  logic [alu_op_pkg::data_w-1:0] dividend,
	input  logic [alu_op_pkg::data_w-1:0] divisor,
	output logic                          busy,
	output logic                          done,
	output exe_types_pkg::hilo_t          quot_rem
);
	import alu_op_pkg::*;

	logic [div_cnt_w-1:0] cnt;
	logic                 last;
	logic                 neg_q;
	logic                 neg_r;
	logic [data_w-1:0]    quo;
	logic [data_w-1:0]    rem;
	logic [data_w-1:0]    dsr;
	logic [data_w-1:0]    mag_a;
	logic [data_w-1:0]    mag_b;
	// shifted partial remainder minus divisor, msb is the borrow
	logic [data_w+1:0]    trial;

	assign mag_a = (is_signed && dividend[data_w-1]) ? -dividend : dividend;
	assign mag_b = (is_signed && divisor[data_w-1]) ? -divisor : divisor;

	assign trial = {1'b0, rem, quo[data_w-1]} - {2'b0, dsr};
	assign last = (cnt == div_cnt_w'(div_cycles - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end else begin
			// one-cycle pulse after the final iteration
			done <= busy && last && !flush;
			if (busy) begin
				cnt <= cnt + 1'b1;
				if (flush || last) begin
					busy <= 1'b0;
				end
			end else if (start && !flush) begin
				busy <= 1'b1;
				cnt <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy) begin
			quo <= mag_a;
			rem <= '0;
			dsr <= mag_b;
			// divide by zero keeps an all-ones quotient
			neg_q <= is_signed && (dividend[data_w-1] ^ divisor[data_w-1]) &&
				(divisor != '0);
			// remainder follows the dividend
			neg_r <= is_signed && dividend[data_w-1];
		end else if (busy) begin
			if (trial[data_w+1]) begin
				rem <= {rem[data_w-2:0], quo[data_w-1]};
			end else begin
				rem <= trial[data_w-1:0];
			end
			quo <= {quo[data_w-2:0], !trial[data_w+1]};
		end
	end

	// sign correction of the magnitudes
	always_comb begin
		quot_rem.hi = neg_r ? -rem : rem;
		quot_rem.lo = neg_q ? -quo : quo;
	end

endmodule

/* logic/exe_stage.sv */
`timescale 1ns/1ns

module exe_stage (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     flush,
	input  exe_types_pkg::exe_req_t  req,
	output exe_types_pkg::exe_resp_t resp,
	output logic                     stall
);
	import exe_types_pkg::*;

	hilo_t wide;
	hilo_t hilo;
	logic  wide_done;

	alu u_alu (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.req       (req),
		.hilo      (hilo),
		.resp      (resp),
		.wide      (wide),
		.wide_done (wide_done),
		.stall     (stall)
	);

	// hi/lo write decided from the op in flight
	hilo_reg u_hilo_reg (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.op        (req.op),
		.num1      (req.num1),
		.wide      (wide),
		.wide_done (wide_done),
		.hilo      (hilo)
	);

endmodule

/* logic/exe_types_pkg.sv */
package exe_types_pkg;

	// operands as delivered by decode, immediates already extended in num2
	typedef struct packed {
		alu_op_pkg::alu_op_e           op;
		logic [alu_op_pkg::data_w-1:0] num1;
		logic [alu_op_pkg::data_w-1:0] num2;
		logic [4:0]                    sa;
	} exe_req_t;

	// single-cycle answer of the execute stage
	typedef struct packed {
		logic [alu_op_pkg::data_w-1:0] result;
		logic                          overflow;
		// branch taken for branches, result zero otherwise
		logic                          zero;
	} exe_resp_t;

	// hi/lo pair, also used for product and {remainder, quotient}
	typedef struct packed {
		logic [alu_op_pkg::data_w-1:0] hi;
		logic [alu_op_pkg::data_w-1:0] lo;
	} hilo_t;

endpackage

/* logic/hilo_reg.sv */
`timescale 1ns/1ns

module hilo_reg (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          flush,
	input  alu_op_pkg::alu_op_e           op,
	input  logic [alu_op_pkg::data_w-1:0] num1,
	input  exe_types_pkg::hilo_t          wide,
	input  logic                          wide_done,
	output exe_types_pkg::hilo_t          hilo
);
	import alu_op_pkg::*;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hilo <= '0;
		end else if (!flush) begin
			case (op)
				// product lands on the edge after the op
				op_mult,
				op_multu: hilo <= wide;
				// quotient and remainder only once the divider is done
				op_div,
				op_divu: begin
					if (wide_done) begin
						hilo <= wide;
					end
				end
				op_mthi: hilo.hi <= num1;
				op_mtlo: hilo.lo <= num1;
				default: begin
					hilo <= hilo;
				end
			endcase
		end
	end

endmodule

/* mips_exe.f */
logic/alu_op_pkg.sv
logic/exe_types_pkg.sv
logic/div.sv
logic/alu.sv
logic/hilo_reg.sv
logic/exe_stage.sv
dv/exe_stage_props.sv
dv/exe_stage_tb.sv
